// ==== verilog.f ====
source/timing_pkg.sv
source/host_pkg.sv
source/host_regs.sv
source/pps_gen.sv
source/gps_period_counter.sv
source/rtc_clock.sv
source/readback_mux.sv
source/timing_core.sv
testbench/tb_timing_core.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps -Wno-fatal \
		-f verilog.f --top-module tb_timing_core -o Vtb_timing_core

run: build
	./obj_dir/Vtb_timing_core > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall \
		-f verilog.f --top-module tb_timing_core

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_timing_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_timing_core
  import host_pkg::*;
  import timing_pkg::*;
();

  localparam int PERIOD = 200;

  logic  CLOCK_BUF;
  logic  reset;
  logic  i_gps_pps;
  byte_t i_mosi_byte;
  logic  i_mosi_byte_valid;
  logic  i_cmd_byte;
  logic  i_miso_byte_req;
  logic  o_pps;
  byte_t o_miso_byte;
  logic  o_miso_byte_valid;

  integer seed;

  // Reference model state, updated on every rising edge
  int          m_cycle;
  int          m_next_pps;
  logic        m_exp_pps;
  logic        m_gps_prev;
  logic        m_gps_edge;
  int          m_last_rise;
  int          m_rise_count;
  count_t      m_period;
  logic        m_align;
  byte_t       m_cmd;
  byte_t       m_idx;
  logic        m_load_pending;
  time_field_t m_set_sec;
  time_field_t m_set_min;
  time_field_t m_set_hour;
  time_field_t m_sec;
  time_field_t m_min;
  time_field_t m_hour;
  int          m_total;

  timing_core #(
    .PPS_PERIOD (PERIOD)
  ) u_timing_core (
    .CLOCK_BUF         (CLOCK_BUF),
    .reset             (reset),
    .i_gps_pps         (i_gps_pps),
    .i_mosi_byte       (i_mosi_byte),
    .i_mosi_byte_valid (i_mosi_byte_valid),
    .i_cmd_byte        (i_cmd_byte),
    .i_miso_byte_req   (i_miso_byte_req),
    .o_pps             (o_pps),
    .o_miso_byte       (o_miso_byte),
    .o_miso_byte_valid (o_miso_byte_valid)
  );

  initial begin
    CLOCK_BUF = 1'b0;
    forever #5 CLOCK_BUF = ~CLOCK_BUF;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %0t %s: got 0x%02h, expected 0x%02h",
                                  $time, name, actual, expected));
    end
  endtask

  task automatic check_pps(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %0t %s: got %b, expected %b",
                                  $time, name, actual, expected));
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Byte the host should see at this command and index
  function automatic byte_t expected_read(input byte_t cmd, input byte_t idx);
    byte_t value;
    value = '0;
    if (cmd[CMD_READ_BIT]) begin
      if (cmd[6:0] == RD_GPS_PERIOD && idx < 8'd4) begin
        value = byte_t'(m_period >> (8 * idx));
      end else if (cmd[6:0] == RD_TIME) begin
        case (idx)
          8'd0: value = m_sec;
          8'd1: value = m_min;
          8'd2: value = m_hour;
          default: value = '0;
        endcase
      end
    end
    return value;
  endfunction

  // Cycle model of the board
  always @(posedge CLOCK_BUF) begin
    if (!reset) begin
      m_cycle        = 0;
      m_next_pps     = PERIOD;
      m_exp_pps      = 1'b0;
      m_gps_prev     = 1'b0;
      m_gps_edge     = 1'b0;
      m_last_rise    = 0;
      m_rise_count   = 0;
      m_period       = '0;
      m_align        = 1'b0;
      m_cmd          = '0;
      m_idx          = '0;
      m_load_pending = 1'b0;
      m_set_sec      = '0;
      m_set_min      = '0;
      m_set_hour     = '0;
      m_sec          = '0;
      m_min          = '0;
      m_hour         = '0;
    end else begin
      m_cycle = m_cycle + 1;
      // RTC sees the pulse and the load one cycle after they are raised
      if (m_load_pending) begin
        m_sec  = m_set_sec;
        m_min  = m_set_min;
        m_hour = m_set_hour;
      end else if (m_exp_pps) begin
        m_total = (int'(m_hour) * 3600 + int'(m_min) * 60 + int'(m_sec) + 1) % 86400;
        m_hour  = time_field_t'(m_total / 3600);
        m_min   = time_field_t'((m_total / 60) % 60);
        m_sec   = time_field_t'(m_total % 60);
      end
      m_gps_edge = i_gps_pps && !m_gps_prev;
      m_gps_prev = i_gps_pps;
      if (m_gps_edge) begin
        if (m_rise_count > 0) begin
          m_period = count_t'(m_cycle - m_last_rise);
        end
        m_last_rise  = m_cycle;
        m_rise_count = m_rise_count + 1;
        if (m_align) begin
          m_next_pps = m_cycle + PERIOD;
        end
      end
      m_exp_pps = (m_cycle == m_next_pps);
      if (m_exp_pps) begin
        m_next_pps = m_next_pps + PERIOD;
      end
      m_load_pending = 1'b0;
      if (i_mosi_byte_valid && i_cmd_byte) begin
        m_cmd = i_mosi_byte;
        m_idx = '0;
      end else if (i_mosi_byte_valid) begin
        if (!m_cmd[CMD_READ_BIT]) begin
          case (m_cmd[6:0])
            ADDR_CONFIG_SET: m_align = m_align | i_mosi_byte[CFG_ALIGN_BIT];
            ADDR_CONFIG_CLR: m_align = m_align & ~i_mosi_byte[CFG_ALIGN_BIT];
            ADDR_SECOND: begin
              m_set_sec      = i_mosi_byte;
              m_load_pending = 1'b1;
            end
            ADDR_MINUTE: begin
              m_set_min      = i_mosi_byte;
              m_load_pending = 1'b1;
            end
            ADDR_HOUR: begin
              m_set_hour     = i_mosi_byte;
              m_load_pending = 1'b1;
            end
            default: ;
          endcase
        end
        m_idx = m_idx + 8'd1;
      end
    end
  end

  // PPS output watched on every cycle
  always @(negedge CLOCK_BUF) begin
    if (reset) begin
      check_pps("o_pps", o_pps, m_exp_pps);
    end
  end

  task automatic send_byte(input byte_t data, input logic is_cmd);
    @(posedge CLOCK_BUF);
    #1;
    i_mosi_byte       = data;
    i_cmd_byte        = is_cmd;
    i_mosi_byte_valid = 1'b1;
    @(posedge CLOCK_BUF);
    #1;
    i_mosi_byte_valid = 1'b0;
    i_cmd_byte        = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input byte_t data);
    send_byte({1'b0, addr}, 1'b1);
    send_byte(data, 1'b0);
  endtask

  task automatic read_and_check(input string name);
    byte_t expected;
    int    waited;
    @(posedge CLOCK_BUF);
    #1;
    i_miso_byte_req = 1'b1;
    @(posedge CLOCK_BUF);
    #1;
    i_miso_byte_req = 1'b0;
    // Byte is picked on the next edge from the state held now
    expected = expected_read(m_cmd, m_idx);
    waited = 0;
    do begin
      @(negedge CLOCK_BUF);
      waited = waited + 1;
    end while (!o_miso_byte_valid && waited < 10);
    if (!o_miso_byte_valid) begin
      stop_with_failure("o_miso_byte_valid never came after a byte request");
    end
    if (waited != 2) begin
      stop_with_failure($sformatf("[FAIL] %0t o_miso_byte_valid: got %0d cycles, expected 2",
                                  $time, waited));
    end
    check_byte(name, o_miso_byte, expected);
  endtask

  // Dummy data byte between reads moves the index on
  task automatic read_value(input addr_t addr, input int nbytes, input string name);
    send_byte({1'b1, addr}, 1'b1);
    for (int i = 0; i < nbytes; i++) begin
      if (i > 0) begin
        send_byte(byte_t'(rand_below(256)), 1'b0);
      end
      read_and_check(name);
    end
  endtask

  task automatic gps_pulse(input int gap);
    repeat (gap) @(posedge CLOCK_BUF);
    #1;
    i_gps_pps = 1'b1;
    repeat (3) @(posedge CLOCK_BUF);
    #1;
    i_gps_pps = 1'b0;
  endtask

  task automatic wait_model_pps();
    int waited;
    waited = 0;
    do begin
      @(negedge CLOCK_BUF);
      waited = waited + 1;
    end while (!m_exp_pps && waited < 2 * PERIOD + 10);
    if (!m_exp_pps) begin
      stop_with_failure("no local PPS pulse was due within two periods");
    end
  endtask

  task automatic wait_until_cycle(input int target);
    int waited;
    waited = 0;
    while (m_cycle != target && waited < 4 * PERIOD) begin
      @(negedge CLOCK_BUF);
      waited = waited + 1;
    end
    if (m_cycle != target) begin
      stop_with_failure("cycle counter never reached the expected PPS cycle");
    end
  endtask

  initial begin
    seed              = 32'h880e0328;
    reset             = 1'b0;
    i_gps_pps         = 1'b0;
    i_mosi_byte       = '0;
    i_mosi_byte_valid = 1'b0;
    i_cmd_byte        = 1'b0;
    i_miso_byte_req   = 1'b0;
    repeat (4) @(posedge CLOCK_BUF);
    #1;
    reset = 1'b1;

    // Free running PPS, GPS edges ignored
    for (int i = 0; i < 6; i++) begin
      gps_pulse(20 + rand_below(160));
    end

    // GPS period readback, two bytes past the end
    for (int i = 0; i < 4; i++) begin
      gps_pulse(5 + rand_below(300));
      gps_pulse(5 + rand_below(300));
      read_value(RD_GPS_PERIOD, 6, "o_miso_byte gps period");
    end

    // Aligned PPS follows the GPS edge
    write_reg(ADDR_CONFIG_SET, 8'h01);
    for (int i = 0; i < 3; i++) begin
      gps_pulse(10 + rand_below(140));
      wait_until_cycle(m_last_rise + PERIOD);
      check_pps("o_pps aligned", o_pps, 1'b1);
    end
    write_reg(ADDR_CONFIG_CLR, 8'h01);
    for (int i = 0; i < 4; i++) begin
      gps_pulse(20 + rand_below(250));
    end

    // Time set, run and read back, first pass wraps the day
    for (int i = 0; i < 6; i++) begin
      wait_model_pps();
      if (i == 0) begin
        write_reg(ADDR_SECOND, 8'd59);
        write_reg(ADDR_MINUTE, 8'd59);
        write_reg(ADDR_HOUR, 8'd23);
      end else begin
        write_reg(ADDR_SECOND, byte_t'(rand_below(60)));
        write_reg(ADDR_MINUTE, byte_t'(rand_below(60)));
        write_reg(ADDR_HOUR, byte_t'(rand_below(24)));
      end
      repeat (1 + rand_below(3)) wait_model_pps();
      read_value(RD_TIME, 4, "o_miso_byte time");
    end

    // Unused read addresses
    for (int i = 0; i < 5; i++) begin
      read_value(addr_t'(5 + rand_below(123)), 2, "o_miso_byte unused address");
    end

    // Data bytes under a read command write nothing
    send_byte({1'b1, ADDR_SECOND}, 1'b1);
    send_byte(byte_t'(rand_below(60)), 1'b0);
    send_byte({1'b1, ADDR_CONFIG_SET}, 1'b1);
    send_byte(8'h01, 1'b0);
    gps_pulse(30 + rand_below(100));
    wait_model_pps();
    read_value(RD_TIME, 3, "o_miso_byte time after read command");
    repeat (2 * PERIOD) @(posedge CLOCK_BUF);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/timing_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module timing_core
  import host_pkg::*;
  import timing_pkg::*;
#(
  parameter pps_cnt_t PPS_PERIOD = DEFAULT_PPS_PERIOD
) (
  input  wire   CLOCK_BUF,
  input  wire   reset,
  input  wire   i_gps_pps,
  input  byte_t i_mosi_byte,
  input  wire   i_mosi_byte_valid,
  input  wire   i_cmd_byte,
  input  wire   i_miso_byte_req,
  output logic  o_pps,
  output byte_t o_miso_byte,
  output logic  o_miso_byte_valid
);

  addr_t       cmd_addr;
  logic        cmd_read;
  logic        align;
  time_field_t time_sec;
  time_field_t time_min;
  time_field_t time_hour;
  logic        rtc_load;
  logic        gps_rise;
  count_t      gps_period;
  time_field_t rtc_sec;
  time_field_t rtc_min;
  time_field_t rtc_hour;

  host_regs u_host_regs (
    .CLOCK_BUF         (CLOCK_BUF),
    .reset             (reset),
    .i_mosi_byte       (i_mosi_byte),
    .i_mosi_byte_valid (i_mosi_byte_valid),
    .i_cmd_byte        (i_cmd_byte),
    .o_cmd_addr        (cmd_addr),
    .o_cmd_read        (cmd_read),
    .o_align           (align),
    .o_time_sec        (time_sec),
    .o_time_min        (time_min),
    .o_time_hour       (time_hour),
    .o_rtc_load        (rtc_load)
  );

  pps_gen #(
    .PPS_PERIOD (PPS_PERIOD)
  ) u_pps_gen (
    .CLOCK_BUF  (CLOCK_BUF),
    .reset      (reset),
    .i_gps_pps  (i_gps_pps),
    .i_align    (align),
    .o_pps      (o_pps),
    .o_gps_rise (gps_rise)
  );

  gps_period_counter u_gps_period_counter (
    .CLOCK_BUF  (CLOCK_BUF),
    .reset      (reset),
    .i_gps_rise (gps_rise),
    .o_period   (gps_period)
  );

  rtc_clock u_rtc_clock (
    .CLOCK_BUF (CLOCK_BUF),
    .reset     (reset),
    .i_pps     (o_pps),
    .i_load    (rtc_load),
    .i_sec     (time_sec),
    .i_min     (time_min),
    .i_hour    (time_hour),
    .o_sec     (rtc_sec),
    .o_min     (rtc_min),
    .o_hour    (rtc_hour)
  );

  readback_mux u_readback_mux (
    .CLOCK_BUF         (CLOCK_BUF),
    .reset             (reset),
    .i_mosi_byte_valid (i_mosi_byte_valid),
    .i_cmd_byte        (i_cmd_byte),
    .i_miso_byte_req   (i_miso_byte_req),
    .i_cmd_addr        (cmd_addr),
    .i_cmd_read        (cmd_read),
    .i_period          (gps_period),
    .i_sec             (rtc_sec),
    .i_min             (rtc_min),
    .i_hour            (rtc_hour),
    .o_miso_byte       (o_miso_byte),
    .o_miso_byte_valid (o_miso_byte_valid)
  );

endmodule

`default_nettype wire

// ==== source/readback_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module readback_mux
  import host_pkg::*;
  import timing_pkg::*;
(
  input  wire         CLOCK_BUF,
  input  wire         reset,
  input  wire         i_mosi_byte_valid,
  input  wire         i_cmd_byte,
  input  wire         i_miso_byte_req,
  input  addr_t       i_cmd_addr,
  input  wire         i_cmd_read,
  input  count_t      i_period,
  input  time_field_t i_sec,
  input  time_field_t i_min,
  input  time_field_t i_hour,
  output byte_t       o_miso_byte,
  output logic        o_miso_byte_valid
);

  byte_t byte_idx;
  byte_t sel_byte;
  logic  req_d1;

  // Value byte at the current index, LSB first
  always_comb begin
    sel_byte = '0;
    if (i_cmd_read) begin
      case (i_cmd_addr)
        RD_GPS_PERIOD: begin
          case (byte_idx)
            8'd0: sel_byte = i_period[7:0];
            8'd1: sel_byte = i_period[15:8];
            8'd2: sel_byte = i_period[23:16];
            8'd3: sel_byte = i_period[31:24];
            default: sel_byte = '0;
          endcase
        end
        RD_TIME: begin
          case (byte_idx)
            8'd0: sel_byte = i_sec;
            8'd1: sel_byte = i_min;
            8'd2: sel_byte = i_hour;
            default: sel_byte = '0;
          endcase
        end
        default: sel_byte = '0;
      endcase
    end
  end

  always_ff @(posedge CLOCK_BUF) begin
    if (!reset) begin
      byte_idx          <= '0;
      req_d1            <= 1'b0;
      o_miso_byte_valid <= 1'b0;
      o_miso_byte       <= '0;
    end else begin
      req_d1            <= i_miso_byte_req;
      o_miso_byte_valid <= req_d1;
      if (req_d1) begin
        o_miso_byte <= sel_byte;
      end
      if (i_mosi_byte_valid && i_cmd_byte) begin
        byte_idx <= '0;
      end else if (i_mosi_byte_valid) begin
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rtc_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtc_clock
  import timing_pkg::*;
(
  input  wire         CLOCK_BUF,
  input  wire         reset,
  input  wire         i_pps,
  input  wire         i_load,
  input  time_field_t i_sec,
  input  time_field_t i_min,
  input  time_field_t i_hour,
  output time_field_t o_sec,
  output time_field_t o_min,
  output time_field_t o_hour
);

  logic sec_wrap;
  logic min_wrap;
  logic fields_ok;

  assign sec_wrap  = (o_sec == SEC_MAX);
  assign min_wrap  = sec_wrap && (o_min == MIN_MAX);
  assign fields_ok = (o_sec <= SEC_MAX) && (o_min <= MIN_MAX) && (o_hour <= HOUR_MAX);

  always_ff @(posedge CLOCK_BUF) begin
    if (!reset) begin
      o_sec  <= '0;
      o_min  <= '0;
      o_hour <= '0;
    end else if (i_load) begin
      // Load wins over a PPS in the same cycle
      o_sec  <= i_sec;
      o_min  <= i_min;
      o_hour <= i_hour;
    end else if (i_pps) begin
      o_sec <= sec_wrap ? '0 : o_sec + 1'b1;
      if (sec_wrap) begin
        o_min <= (o_min == MIN_MAX) ? '0 : o_min + 1'b1;
      end
      if (min_wrap) begin
        o_hour <= (o_hour == HOUR_MAX) ? '0 : o_hour + 1'b1;
      end
    end
  end

  // Only a host load can take a field out of range
  a_fields_in_range: assert property (
    @(posedge CLOCK_BUF) disable iff (!reset)
    (fields_ok && !i_load) |=> fields_ok
  );

endmodule

`default_nettype wire

// ==== source/gps_period_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_period_counter
  import timing_pkg::*;
(
  input  wire    CLOCK_BUF,
  input  wire    reset,
  input  wire    i_gps_rise,
  output count_t o_period
);

  count_t cycle_cnt;

  // Counter starts at 1 so the latched value equals the edge spacing
  always_ff @(posedge CLOCK_BUF) begin
    if (!reset) begin
      cycle_cnt <= '0;
      o_period  <= '0;
    end else begin
      if (i_gps_rise) begin
        o_period  <= cycle_cnt;
        cycle_cnt <= 32'd1;
      end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pps_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pps_gen
  import timing_pkg::*;
#(
  parameter pps_cnt_t PPS_PERIOD = DEFAULT_PPS_PERIOD
) (
  input  wire  CLOCK_BUF,
  input  wire  reset,
  input  wire  i_gps_pps,
  input  wire  i_align,
  output logic o_pps,
  output logic o_gps_rise
);

  localparam pps_cnt_t LAST_COUNT = pps_cnt_t'(PPS_PERIOD - 1);

  logic     gps_pps_d;
  pps_cnt_t pps_cnt;

  // Edge seen on the first edge that samples the pulse high
  assign o_gps_rise = i_gps_pps && !gps_pps_d;

  always_ff @(posedge CLOCK_BUF) begin
    if (!reset) begin
      gps_pps_d <= 1'b0;
      pps_cnt   <= '0;
      o_pps     <= 1'b0;
    end else begin
      gps_pps_d <= i_gps_pps;
      if (i_align && o_gps_rise) begin
        pps_cnt <= '0;
        o_pps   <= 1'b0;
      end else if (pps_cnt == LAST_COUNT) begin
        pps_cnt <= '0;
        o_pps   <= 1'b1;
      end else begin
        pps_cnt <= pps_cnt + 1'b1;
        o_pps   <= 1'b0;
      end
    end
  end

  a_pps_single: assert property (
    @(posedge CLOCK_BUF) disable iff (!reset)
    o_pps |=> !o_pps
  );

endmodule

`default_nettype wire

// ==== source/host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_regs
  import host_pkg::*;
  import timing_pkg::*;
(
  input  wire         CLOCK_BUF,
  input  wire         reset,
  input  byte_t       i_mosi_byte,
  input  wire         i_mosi_byte_valid,
  input  wire         i_cmd_byte,
  output addr_t       o_cmd_addr,
  output logic        o_cmd_read,
  output logic        o_align,
  output time_field_t o_time_sec,
  output time_field_t o_time_min,
  output time_field_t o_time_hour,
  output logic        o_rtc_load
);

  byte_t cmd_reg;
  byte_t config_reg;
  logic  data_wr;
  logic  time_wr;

  assign o_cmd_addr = cmd_reg[6:0];
  assign o_cmd_read = cmd_reg[CMD_READ_BIT];
  assign o_align    = config_reg[CFG_ALIGN_BIT];

  // Data byte under a write command
  assign data_wr = i_mosi_byte_valid && !i_cmd_byte && !o_cmd_read;
  assign time_wr = data_wr && (o_cmd_addr == ADDR_SECOND || o_cmd_addr == ADDR_MINUTE ||
                               o_cmd_addr == ADDR_HOUR);

  always_ff @(posedge CLOCK_BUF) begin
    if (!reset) begin
      cmd_reg    <= '0;
      config_reg <= '0;
      o_rtc_load <= 1'b0;
    end else begin
      if (i_mosi_byte_valid && i_cmd_byte) begin
        cmd_reg <= i_mosi_byte;
      end
      if (data_wr && o_cmd_addr == ADDR_CONFIG_SET) begin
        config_reg <= config_reg | i_mosi_byte;
      end else if (data_wr && o_cmd_addr == ADDR_CONFIG_CLR) begin
        config_reg <= config_reg & ~i_mosi_byte;
      end
      // RTC picks up all three fields one cycle later
      o_rtc_load <= time_wr;
    end
  end

  always_ff @(posedge CLOCK_BUF) begin
    if (!reset) begin
      o_time_sec  <= '0;
      o_time_min  <= '0;
      o_time_hour <= '0;
    end else begin
      if (data_wr && o_cmd_addr == ADDR_SECOND) begin
        o_time_sec <= i_mosi_byte;
      end
      if (data_wr && o_cmd_addr == ADDR_MINUTE) begin
        o_time_min <= i_mosi_byte;
      end
      if (data_wr && o_cmd_addr == ADDR_HOUR) begin
        o_time_hour <= i_mosi_byte;
      end
    end
  end

  // Host spaces its data bytes, so a load never lasts two cycles
  a_rtc_load_single: assert property (
    @(posedge CLOCK_BUF) disable iff (!reset)
    o_rtc_load |=> !o_rtc_load
  );

endmodule

`default_nettype wire

// ==== source/host_pkg.sv ====
`default_nettype none

package host_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;

  // Command byte, bit 7 set for a read, low bits are the address
  localparam int CMD_READ_BIT = 7;

  // Write addresses
  localparam addr_t ADDR_CONFIG_SET = 7'd0;
  localparam addr_t ADDR_SECOND     = 7'd1;
  localparam addr_t ADDR_MINUTE     = 7'd2;
  localparam addr_t ADDR_HOUR       = 7'd3;
  localparam addr_t ADDR_CONFIG_CLR = 7'd14;

  // Read addresses
  localparam addr_t RD_GPS_PERIOD = 7'd0;
  localparam addr_t RD_TIME       = 7'd4;

  // Config register bits
  localparam int CFG_ALIGN_BIT = 0;

endpackage

`default_nettype wire

// ==== source/timing_pkg.sv ====
`default_nettype none

package timing_pkg;

  // Cycle count between GPS edges
  typedef logic [31:0] count_t;

  // Local PPS counter
  typedef logic [31:0] pps_cnt_t;

  // One RTC field
  typedef logic [7:0] time_field_t;

  // 10 MHz reference, one pulse per second
  localparam pps_cnt_t DEFAULT_PPS_PERIOD = 32'd10_000_000;

  // Field limits, inclusive
  localparam time_field_t SEC_MAX  = 8'd59;
  localparam time_field_t MIN_MAX  = 8'd59;
  localparam time_field_t HOUR_MAX = 8'd23;

endpackage

`default_nettype wire
